// File: exec_pkg.sv
//****************************
// Integer execution unit types
// Widths, operation encodings, issue and result structs
//****************************
package exec_pkg;

  localparam int DATA_W  = 64;
  localparam int SHAMT_W = 6;
  localparam int FLAG_W  = 4;

  localparam logic [7:0] CSR_CTRL_ADDR = 8'h00;

  typedef enum logic [1:0] {
    unit_arith = 2'd0,
    unit_logic = 2'd1,
    unit_shift = 2'd2,
    unit_mul   = 2'd3
  } unit_e;

  typedef enum logic [2:0] {
    code_add = 3'd0,
    code_sub = 3'd1,
    code_cmp = 3'd2,
    code_and = 3'd3,
    code_or  = 3'd4,
    code_xor = 3'd5
  } arith_code_e;

  typedef enum logic {
    dir_left  = 1'b0,
    dir_right = 1'b1
  } shift_dir_e;

  // Arithmetic, logic and multiply view of the operation word
  typedef struct packed {
    unit_e       unit;
    arith_code_e code;
    logic        is64;
    logic [5:0]  rsvd;
  } op_arith_t;

  // Shift view, unit stays in the same top bits
  typedef struct packed {
    unit_e              unit;
    shift_dir_e         dir;
    logic               arith;
    logic               is64;
    logic               imm_en;
    logic [SHAMT_W-1:0] imm_amt;
  } op_shift_t;

  typedef union packed {
    op_arith_t arith;
    op_shift_t shift;
  } op_word_u;

  typedef struct packed {
    logic       fwd;
    logic       late;
    logic [3:0] bus_idx;
  } src_sel_t;

  typedef struct packed {
    logic              valid;
    op_word_u          op;
    logic [DATA_W-1:0] a_val;
    logic [DATA_W-1:0] b_val;
    src_sel_t          a_sel;
    src_sel_t          b_sel;
  } issue_t;

  typedef struct packed {
    logic               valid;
    unit_e              unit;
    arith_code_e        code;
    logic               is64;
    shift_dir_e         dir;
    logic               arith;
    logic               imm_en;
    logic [SHAMT_W-1:0] imm_amt;
  } exec_ctrl_t;

  // Flags from msb down: zero, carry, sign, overflow
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [FLAG_W-1:0] flags;
  } result_t;

  typedef struct packed {
    logic [30:0] rsvd;
    logic        sext32;
  } ctrl_reg_t;

endpackage

// File: exec_csr_apb.sv
//****************************
// APB slave for the unit control register
//****************************
`timescale 1ns/1ns

module exec_csr_apb (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output exec_pkg::ctrl_reg_t ctrl
);

  logic sext32_q;
  logic hit;
  logic access;

  assign hit    = paddr == exec_pkg::CSR_CTRL_ADDR;
  assign access = psel && penable;

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !hit;
  assign ctrl    = '{rsvd: '0, sext32: sext32_q};
  assign prdata  = (psel && hit) ? ctrl : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sext32_q <= 1'b0;
    end else if (access && pwrite && hit) begin
      sext32_q <= pwdata[0];
    end
  end

  a_enable_in_select: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(penable) |-> psel);

endmodule

// File: operand_bypass.sv
//****************************
// Source operand bypass
// Register value, current bus or one-cycle-old bus
//****************************
`timescale 1ns/1ns

module operand_bypass #(
  parameter int NUM_BUS = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    capture,
  input  logic [exec_pkg::DATA_W-1:0]             reg_val,
  input  exec_pkg::src_sel_t                      sel,
  input  logic [NUM_BUS-1:0][exec_pkg::DATA_W-1:0] fwd_bus,
  output logic [exec_pkg::DATA_W-1:0]             operand
);

  logic [NUM_BUS-1:0][exec_pkg::DATA_W-1:0] bus_q;
  logic [exec_pkg::DATA_W-1:0]              chosen;

  // Every bus is copied each cycle for the late path
  always_ff @(posedge clk) begin
    bus_q <= fwd_bus;
  end

  always_comb begin
    if (!sel.fwd) begin
      chosen = reg_val;
    end else if (sel.late) begin
      chosen = bus_q[sel.bus_idx];
    end else begin
      chosen = fwd_bus[sel.bus_idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      operand <= '0;
    end else if (capture) begin
      operand <= chosen;
    end
  end

  a_bus_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    capture && sel.fwd |-> sel.bus_idx < NUM_BUS);

endmodule

// File: op_decode.sv
//****************************
// Issue-stage operation decode
// Registers the execute control at accept
//****************************
`timescale 1ns/1ns

module op_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  exec_pkg::op_word_u   issue_op,
  input  logic                 accept,
  output exec_pkg::exec_ctrl_t ctrl,
  output logic                 mul_start,
  output logic                 mul_is64
);

  exec_pkg::exec_ctrl_t dec;
  logic                 is_mul;

  assign is_mul = issue_op.arith.unit == exec_pkg::unit_mul;

  // The unit field picks which view of the word to read
  always_comb begin
    dec      = '0;
    dec.unit = issue_op.arith.unit;
    case (issue_op.arith.unit)
      exec_pkg::unit_shift: begin
        dec.valid   = 1'b1;
        dec.is64    = issue_op.shift.is64;
        dec.dir     = issue_op.shift.dir;
        dec.arith   = issue_op.shift.arith;
        dec.imm_en  = issue_op.shift.imm_en;
        dec.imm_amt = issue_op.shift.imm_amt;
      end
      exec_pkg::unit_mul: begin
        dec.is64 = issue_op.arith.is64;
      end
      default: begin
        dec.valid = 1'b1;
        dec.code  = issue_op.arith.code;
        dec.is64  = issue_op.arith.is64;
      end
    endcase
  end

  // Fields other than valid hold until the next accept, so the
  // ALU still sees the size of a multiply when it finishes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl      <= '0;
      mul_start <= 1'b0;
      mul_is64  <= 1'b0;
    end else if (accept) begin
      ctrl      <= dec;
      mul_start <= is_mul;
      mul_is64  <= is_mul ? dec.is64 : mul_is64;
    end else begin
      ctrl.valid <= 1'b0;
      mul_start  <= 1'b0;
    end
  end

endmodule

// File: int_shifter.sv
//****************************
// 32/64-bit integer shifter
//****************************
`timescale 1ns/1ns

module int_shifter (
  input  exec_pkg::exec_ctrl_t        ctrl,
  input  logic [exec_pkg::DATA_W-1:0] a,
  input  logic [exec_pkg::DATA_W-1:0] b,
  output logic [exec_pkg::DATA_W-1:0] shifted
);

  localparam int W = exec_pkg::DATA_W;

  logic [exec_pkg::SHAMT_W-1:0] amt;
  logic [exec_pkg::SHAMT_W-1:0] amt_eff;
  logic                         fill;
  logic [W-1:0]                 src;
  logic [2*W-1:0]               wide;

  assign amt     = ctrl.imm_en ? ctrl.imm_amt : b[exec_pkg::SHAMT_W-1:0];
  assign amt_eff = ctrl.is64 ? amt : {1'b0, amt[exec_pkg::SHAMT_W-2:0]};

  // Fill bit for right shifts, taken from the top of the operation size
  assign fill = ctrl.arith && (ctrl.is64 ? a[W-1] : a[31]);
  assign src  = ctrl.is64 ? a : {{(W-32){fill}}, a[31:0]};
  assign wide = {{W{fill}}, src} >> amt_eff;

  always_comb begin
    if (ctrl.dir == exec_pkg::dir_left) begin
      shifted = src << amt_eff;
    end else begin
      shifted = wide[W-1:0];
    end
  end

endmodule

// File: mul_step_counter.sv
//****************************
// Multiply step counter
//****************************
`timescale 1ns/1ns

module mul_step_counter #(
  parameter int MUL_BITS_PER_STEP = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  output logic last
);

  localparam int STEPS = exec_pkg::DATA_W / MUL_BITS_PER_STEP;
  localparam int CNT_W = $clog2(STEPS);

  logic [CNT_W-1:0] count_q;
  logic             running_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (load) begin
      count_q   <= CNT_W'(STEPS - 1);
      running_q <= 1'b1;
    end else if (running_q) begin
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign last = running_q && count_q == '0;

endmodule

// File: mul_sequencer.sv
//****************************
// Multiply sequencer
// Load, steps, result edge; holds off issue meanwhile
//****************************
`timescale 1ns/1ns

module mul_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic last,
  output logic load,
  output logic step,
  output logic done,
  output logic issue_ready
);

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_run    = 2'd1,
    st_finish = 2'd2
  } mul_state_e;

  mul_state_e state_q;
  mul_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (start) state_d = st_run;
      st_run:    if (last) state_d = st_finish;
      st_finish: state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign load = (state_q == st_idle) && start;
  assign step = state_q == st_run;
  assign done = state_q == st_finish;
  // start is already high in the cycle after a multiply is accepted
  assign issue_ready = (state_q == st_idle) && !start;

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> state_q == st_idle);

endmodule

// File: mul_datapath.sv
//****************************
// Shift-and-add multiplier
// Retires several multiplier bits per step
//****************************
`timescale 1ns/1ns

module mul_datapath #(
  parameter int MUL_BITS_PER_STEP = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        load,
  input  logic                        step,
  input  logic                        is64,
  input  logic [exec_pkg::DATA_W-1:0] a,
  input  logic [exec_pkg::DATA_W-1:0] b,
  output logic [exec_pkg::DATA_W-1:0] product
);

  localparam int W = exec_pkg::DATA_W;

  logic [W-1:0] mcand_q;
  logic [W-1:0] mplier_q;
  logic [W-1:0] acc_q;
  logic [W-1:0] partial;

  // A times the low multiplier digit
  always_comb begin
    partial = '0;
    for (int i = 0; i < MUL_BITS_PER_STEP; i++) begin
      if (mplier_q[i]) begin
        partial = partial + (mcand_q << i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= is64 ? a : {{(W-32){1'b0}}, a[31:0]};
      mplier_q <= is64 ? b : {{(W-32){1'b0}}, b[31:0]};
    end else if (step) begin
      mcand_q  <= mcand_q << MUL_BITS_PER_STEP;
      mplier_q <= mplier_q >> MUL_BITS_PER_STEP;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (load) begin
      acc_q <= '0;
    end else if (step) begin
      acc_q <= acc_q + partial;
    end
  end

  assign product = acc_q;

endmodule

// File: int_alu.sv
//****************************
// Integer ALU and result port
// Merges ALU, shifter and multiplier results
//****************************
`timescale 1ns/1ns

module int_alu (
  input  logic                        clk,
  input  logic                        rst_n,
  input  exec_pkg::exec_ctrl_t        ctrl,
  input  logic [exec_pkg::DATA_W-1:0] a,
  input  logic [exec_pkg::DATA_W-1:0] b,
  input  logic [exec_pkg::DATA_W-1:0] shifted,
  input  logic [exec_pkg::DATA_W-1:0] product,
  input  logic                        mul_done,
  input  logic                        sext32,
  output exec_pkg::result_t           result
);

  localparam int W = exec_pkg::DATA_W;

  logic                        sub_op;
  logic                        is_arith;
  logic [W-1:0]                b_eff;
  logic [W:0]                  sum_w;
  logic [32:0]                 sum_lo;
  logic                        carry_out;
  logic                        ovf;
  logic [W-1:0]                raw;
  logic [W-1:0]                kept;
  logic [W-1:0]                ext;
  logic                        zero;
  logic                        sign;
  logic                        valid_q;
  logic [W-1:0]                data_q;
  logic [exec_pkg::FLAG_W-1:0] flags_q;

  assign is_arith = !mul_done && ctrl.unit == exec_pkg::unit_arith;
  assign sub_op   = ctrl.code == exec_pkg::code_sub || ctrl.code == exec_pkg::code_cmp;

  // Subtract as A plus inverted B plus one
  assign b_eff  = sub_op ? ~b : b;
  assign sum_w  = {1'b0, a} + {1'b0, b_eff} + {{W{1'b0}}, sub_op};
  assign sum_lo = {1'b0, a[31:0]} + {1'b0, b_eff[31:0]} + {32'b0, sub_op};

  assign carry_out = ctrl.is64 ? sum_w[W] : sum_lo[32];
  assign ovf = ctrl.is64 ? (a[W-1] == b_eff[W-1]) && (sum_w[W-1] != a[W-1])
                         : (a[31] == b_eff[31]) && (sum_w[31] != a[31]);

  always_comb begin
    raw = product;
    if (!mul_done) begin
      case (ctrl.unit)
        exec_pkg::unit_arith: raw = sum_w[W-1:0];
        exec_pkg::unit_logic: begin
          case (ctrl.code)
            exec_pkg::code_or:  raw = a | b;
            exec_pkg::code_xor: raw = a ^ b;
            default:            raw = a & b;
          endcase
        end
        exec_pkg::unit_shift: raw = shifted;
        default:              raw = product;
      endcase
    end
  end

  // Flags come from the raw value, so cmp keeps them with zero data
  assign zero = ctrl.is64 ? raw == '0 : raw[31:0] == 32'b0;
  assign sign = ctrl.is64 ? raw[W-1] : raw[31];
  assign kept = (is_arith && ctrl.code == exec_pkg::code_cmp) ? '0 : raw;
  assign ext  = ctrl.is64 ? kept : {{(W-32){sext32 & kept[31]}}, kept[31:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ctrl.valid || mul_done;
    end
  end

  always_ff @(posedge clk) begin
    data_q  <= ext;
    flags_q <= {zero, is_arith && (sub_op ? !carry_out : carry_out), sign, is_arith && ovf};
  end

  assign result = '{valid: valid_q, data: data_q, flags: flags_q};

  a_no_result_clash: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.valid && mul_done));

endmodule

// File: int_exec_unit.sv
//****************************
// Integer execution unit top
// Bypass, decode, ALU, shifter, multiplier, APB control
//****************************
`timescale 1ns/1ns

module int_exec_unit #(
  parameter int NUM_BUS           = 4,
  parameter int MUL_BITS_PER_STEP = 2
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  exec_pkg::issue_t                         issue,
  output logic                                     issue_ready,
  input  logic [NUM_BUS-1:0][exec_pkg::DATA_W-1:0] fwd_bus,
  output exec_pkg::result_t                        result,
  input  logic [7:0]                               paddr,
  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [31:0]                              pwdata,
  output logic [31:0]                              prdata,
  output logic                                     pready,
  output logic                                     pslverr
);

  exec_pkg::ctrl_reg_t         csr;
  exec_pkg::exec_ctrl_t        ex_ctrl;
  logic                        accept;
  logic [exec_pkg::DATA_W-1:0] opnd_a;
  logic [exec_pkg::DATA_W-1:0] opnd_b;
  logic [exec_pkg::DATA_W-1:0] shifted;
  logic [exec_pkg::DATA_W-1:0] product;
  logic                        mul_start;
  logic                        mul_is64;
  logic                        mul_load;
  logic                        mul_step;
  logic                        mul_last;
  logic                        mul_done;

  assign accept = issue.valid & issue_ready;

  exec_csr_apb u_csr (
    .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .ctrl(csr)
  );

  operand_bypass #(.NUM_BUS(NUM_BUS)) u_bypass_a (
    .clk, .rst_n, .capture(accept), .reg_val(issue.a_val),
    .sel(issue.a_sel), .fwd_bus, .operand(opnd_a)
  );

  operand_bypass #(.NUM_BUS(NUM_BUS)) u_bypass_b (
    .clk, .rst_n, .capture(accept), .reg_val(issue.b_val),
    .sel(issue.b_sel), .fwd_bus, .operand(opnd_b)
  );

  op_decode u_decode (
    .clk, .rst_n, .issue_op(issue.op), .accept,
    .ctrl(ex_ctrl), .mul_start, .mul_is64
  );

  int_shifter u_shifter (.ctrl(ex_ctrl), .a(opnd_a), .b(opnd_b), .shifted);

  mul_step_counter #(.MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)) u_mul_cnt (
    .clk, .rst_n, .load(mul_load), .last(mul_last)
  );

  mul_sequencer u_mul_seq (
    .clk, .rst_n, .start(mul_start), .last(mul_last), .load(mul_load),
    .step(mul_step), .done(mul_done), .issue_ready
  );

  mul_datapath #(.MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)) u_mul_dp (
    .clk, .rst_n, .load(mul_load), .step(mul_step), .is64(mul_is64),
    .a(opnd_a), .b(opnd_b), .product
  );

  int_alu u_alu (
    .clk, .rst_n, .ctrl(ex_ctrl), .a(opnd_a), .b(opnd_b), .shifted,
    .product, .mul_done, .sext32(csr.sext32), .result
  );

endmodule

// File: tb_int_exec.sv
//****************************
// Testbench for the integer execution unit
// Table-driven issue, in-order result checks, APB
//****************************
`timescale 1ns/1ns

module tb_int_exec;

  localparam int NB       = 4;
  localparam int BITS     = 2;
  localparam int ALU_LAT  = 1;
  localparam int MUL_LAT  = 64 / BITS + 2;
  localparam int MAX_ROWS = 64;

  typedef struct {
    exec_pkg::op_word_u       op;
    logic [63:0]              a_val;
    logic [63:0]              b_val;
    exec_pkg::src_sel_t       a_sel;
    exec_pkg::src_sel_t       b_sel;
    logic [NB-1:0][63:0]      bus_cur;
    logic [NB-1:0][63:0]      bus_prev;
    logic                     sext;
    logic                     is_mul;
    logic [63:0]              exp_data;
    logic [3:0]               exp_flags;
  } row_t;

  typedef struct {
    int          row;
    int          accept_edge;
    int          lat;
    logic [63:0] data;
    logic [3:0]  flags;
  } expect_t;

  logic                clk;
  logic                rst_n;
  exec_pkg::issue_t    issue;
  logic                issue_ready;
  logic [NB-1:0][63:0] fwd_bus;
  exec_pkg::result_t   result;
  logic [7:0]          paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;

  row_t    rows[MAX_ROWS];
  int      num_rows;
  logic    sext_phase;
  logic    csr_sext;
  expect_t pending[$];
  int      edge_cnt;

  int_exec_unit #(.NUM_BUS(NB), .MUL_BITS_PER_STEP(BITS)) uut (
    .clk, .rst_n, .issue, .issue_ready, .fwd_bus, .result,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  always #5 clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  function automatic exec_pkg::op_word_u mk_arith(input exec_pkg::unit_e u,
                                                  input exec_pkg::arith_code_e c,
                                                  input logic is64);
    exec_pkg::op_word_u w;
    w.arith = '{unit: u, code: c, is64: is64, rsvd: 6'b0};
    return w;
  endfunction

  function automatic exec_pkg::op_word_u mk_shift(input exec_pkg::shift_dir_e d,
                                                  input logic ar, input logic is64,
                                                  input logic imm_en, input logic [5:0] amt);
    exec_pkg::op_word_u w;
    w.shift = '{unit: exec_pkg::unit_shift, dir: d, arith: ar, is64: is64,
                imm_en: imm_en, imm_amt: amt};
    return w;
  endfunction

  function automatic exec_pkg::src_sel_t src(input logic fwd, input logic late,
                                             input logic [3:0] idx);
    return '{fwd: fwd, late: late, bus_idx: idx};
  endfunction

  // Expected data and flags, from the operation rules
  function automatic void ref_exec(input exec_pkg::op_word_u op, input logic [63:0] a,
                                   input logic [63:0] b, input logic sext,
                                   output logic [63:0] data, output logic [3:0] flags);
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r;
    logic [64:0] w;
    logic [31:0] r32;
    logic [5:0]  amt;
    logic        is64;
    logic        c;
    logic        v;
    logic        is_cmp;
    is64   = (op.arith.unit == exec_pkg::unit_shift) ? op.shift.is64 : op.arith.is64;
    x      = is64 ? a : {32'b0, a[31:0]};
    y      = is64 ? b : {32'b0, b[31:0]};
    c      = 1'b0;
    v      = 1'b0;
    is_cmp = 1'b0;
    r      = '0;
    case (op.arith.unit)
      exec_pkg::unit_arith: begin
        if (op.arith.code == exec_pkg::code_add) begin
          w = {1'b0, x} + {1'b0, y};
          r = w[63:0];
          c = is64 ? w[64] : w[32];
          v = is64 ? (x[63] == y[63] && r[63] != x[63]) : (x[31] == y[31] && r[31] != x[31]);
        end else begin
          r      = x - y;
          c      = x < y;
          v      = is64 ? (x[63] != y[63] && r[63] != x[63])
                        : (x[31] != y[31] && r[31] != x[31]);
          is_cmp = op.arith.code == exec_pkg::code_cmp;
        end
      end
      exec_pkg::unit_logic: begin
        if (op.arith.code == exec_pkg::code_or) r = x | y;
        else if (op.arith.code == exec_pkg::code_xor) r = x ^ y;
        else r = x & y;
      end
      exec_pkg::unit_shift: begin
        amt = op.shift.imm_en ? op.shift.imm_amt : b[5:0];
        if (!is64) amt[5] = 1'b0;
        if (op.shift.dir == exec_pkg::dir_left) begin
          r = x << amt;
        end else if (is64) begin
          if (op.shift.arith) r = $signed(x) >>> amt;
          else r = x >> amt;
        end else begin
          if (op.shift.arith) r32 = $signed(x[31:0]) >>> amt;
          else r32 = x[31:0] >> amt;
          r = {32'b0, r32};
        end
      end
      default: r = x * y;
    endcase
    flags = {is64 ? r == 64'b0 : r[31:0] == 32'b0, c, is64 ? r[63] : r[31], v};
    data  = is_cmp ? 64'b0 : r;
    if (!is64) data = {{32{sext & data[31]}}, data[31:0]};
  endfunction

  task automatic add_row(input exec_pkg::op_word_u op, input logic [63:0] a_val,
                         input logic [63:0] b_val, input exec_pkg::src_sel_t a_sel,
                         input exec_pkg::src_sel_t b_sel);
    row_t        r;
    logic [63:0] a;
    logic [63:0] b;
    r.op     = op;
    r.a_val  = a_val;
    r.b_val  = b_val;
    r.a_sel  = a_sel;
    r.b_sel  = b_sel;
    r.sext   = sext_phase;
    r.is_mul = op.arith.unit == exec_pkg::unit_mul;
    for (int i = 0; i < NB; i++) begin
      r.bus_cur[i]  = rand64();
      r.bus_prev[i] = (num_rows == 0) ? rand64() : rows[num_rows-1].bus_cur[i];
    end
    a = !a_sel.fwd ? a_val : a_sel.late ? r.bus_prev[a_sel.bus_idx] : r.bus_cur[a_sel.bus_idx];
    b = !b_sel.fwd ? b_val : b_sel.late ? r.bus_prev[b_sel.bus_idx] : r.bus_cur[b_sel.bus_idx];
    ref_exec(op, a, b, sext_phase, r.exp_data, r.exp_flags);
    rows[num_rows] = r;
    num_rows++;
  endtask

  task automatic build_phase(input logic full);
    exec_pkg::src_sel_t rs;
    rs = src(1'b0, 1'b0, 4'd0);
    for (int s = 1; s >= 0; s--) begin
      if (full || s == 0) begin
        add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_add, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_sub, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_cmp, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_logic, exec_pkg::code_and, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_logic, exec_pkg::code_or, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_logic, exec_pkg::code_xor, s), rand64(), rand64(), rs, rs);
        for (int k = 0; k < 3; k++) begin
          add_row(mk_shift(exec_pkg::shift_dir_e'(k != 0), k == 2, s, 1'b1, 6'($urandom())),
                  {1'b1, 63'(rand64())}, rand64(), rs, rs);
          add_row(mk_shift(exec_pkg::shift_dir_e'(k != 0), k == 2, s, 1'b0, 6'd0),
                  {1'b1, 63'(rand64())}, rand64(), rs, rs);
        end
        add_row(mk_arith(exec_pkg::unit_mul, exec_pkg::code_add, s), rand64(), rand64(), rs, rs);
        add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_add, s), rand64(), rand64(), rs, rs);
      end
    end
    if (full) begin
      // Overflow, borrow and equal compare corners
      add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_add, 1'b1),
              64'h7fff_ffff_ffff_ffff, 64'd1, rs, rs);
      add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_sub, 1'b0), 64'd1, 64'd2, rs, rs);
      add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_cmp, 1'b1), 64'h55, 64'h55, rs, rs);
      add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_add, 1'b1), 64'd0, 64'd0,
              src(1'b1, 1'b0, 4'd1), src(1'b1, 1'b1, 4'd2));
      add_row(mk_arith(exec_pkg::unit_arith, exec_pkg::code_sub, 1'b1), 64'd0, rand64(),
              src(1'b1, 1'b1, 4'd3), rs);
      add_row(mk_arith(exec_pkg::unit_logic, exec_pkg::code_xor, 1'b1), rand64(), 64'd0,
              rs, src(1'b1, 1'b0, 4'd0));
      add_row(mk_arith(exec_pkg::unit_logic, exec_pkg::code_or, 1'b0), 64'd0, 64'd0,
              src(1'b1, 1'b1, 4'd1), src(1'b1, 1'b1, 4'd1));
    end
  endtask

  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic exp_err, input logic [31:0] exp_rdata);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    assert (pready == 1'b1)
      else stop_on_error($sformatf("FAIL pready addr %h: got %h expected %h",
                                   addr, pready, 1'b1));
    assert (pslverr == exp_err)
      else stop_on_error($sformatf("FAIL pslverr addr %h: got %h expected %h",
                                   addr, pslverr, exp_err));
    if (!wr) begin
      assert (prdata == exp_rdata)
        else stop_on_error($sformatf("FAIL prdata: got %h expected %h", prdata, exp_rdata));
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Results leave in issue order
  always @(negedge clk) begin
    expect_t e;
    if (rst_n && result.valid) begin
      if (pending.size() == 0) begin
        stop_on_error("A result appeared with no instruction outstanding");
      end else begin
        e = pending.pop_front();
        assert (edge_cnt - e.accept_edge == e.lat)
          else stop_on_error($sformatf("FAIL result latency row %0d: got %h expected %h",
                                       e.row, edge_cnt - e.accept_edge, e.lat));
        assert (result.data == e.data)
          else stop_on_error($sformatf("FAIL result.data row %0d: got %h expected %h",
                                       e.row, result.data, e.data));
        assert (result.flags == e.flags)
          else stop_on_error($sformatf("FAIL result.flags row %0d: got %h expected %h",
                                       e.row, result.flags, e.flags));
      end
    end
  end

  initial begin
    #((MAX_ROWS * 40 + 200) * 10);
    $display("Timeout: the unit stopped producing results");
    $display("tests failed");
    $fatal(1);
  end

  initial begin
    int      wait_cnt;
    logic    prev_mul;
    expect_t e;
    void'($urandom(32'hcc50_23cc));
    clk      = 1'b0;
    rst_n    = 1'b0;
    edge_cnt = 0;
    issue    = '0;
    fwd_bus  = '0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    csr_sext = 1'b0;
    num_rows   = 0;
    sext_phase = 1'b0;
    build_phase(1'b1);
    sext_phase = 1'b1;
    build_phase(1'b0);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (!result.valid && issue_ready && !pslverr)
      else stop_on_error("Outputs are not in their reset state");
    apb_access(8'h00, 1'b0, '0, 1'b0, 32'h0);
    @(negedge clk);
    fwd_bus  = rows[0].bus_prev;
    prev_mul = 1'b0;
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clk);
      if (rows[i].sext !== csr_sext) begin
        issue.valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
        // Reserved bits are written as ones and must read back as zero
        apb_access(8'h00, 1'b1, {31'h7fff_ffff, rows[i].sext}, 1'b0, '0);
        apb_access(8'h00, 1'b0, '0, 1'b0, {31'b0, rows[i].sext});
        apb_access(8'h10, 1'b1, {31'h7fff_ffff, ~rows[i].sext}, 1'b1, '0);
        apb_access(8'h10, 1'b0, '0, 1'b1, 32'h0);
        apb_access(8'h00, 1'b0, '0, 1'b0, {31'b0, rows[i].sext});
        csr_sext = rows[i].sext;
        @(negedge clk);
        prev_mul = 1'b0;
      end
      wait_cnt = 0;
      while (!issue_ready) begin
        issue.valid = 1'b0;
        wait_cnt++;
        @(negedge clk);
      end
      assert (wait_cnt == (prev_mul ? MUL_LAT : 0))
        else stop_on_error($sformatf("FAIL issue_ready low cycles row %0d: got %h expected %h",
                                     i, wait_cnt, prev_mul ? MUL_LAT : 0));
      fwd_bus = rows[i].bus_cur;
      issue   = '{valid: 1'b1, op: rows[i].op, a_val: rows[i].a_val, b_val: rows[i].b_val,
                  a_sel: rows[i].a_sel, b_sel: rows[i].b_sel};
      e = '{row: i, accept_edge: edge_cnt + 1, lat: rows[i].is_mul ? MUL_LAT : ALU_LAT,
            data: rows[i].exp_data, flags: rows[i].exp_flags};
      pending.push_back(e);
      prev_mul = rows[i].is_mul;
    end
    @(negedge clk);
    issue.valid = 1'b0;
    repeat (MUL_LAT + 4) @(negedge clk);
    if (pending.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Results missing for %0d instructions", pending.size());
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

// File: tb.f
exec_pkg.sv
exec_csr_apb.sv
operand_bypass.sv
op_decode.sv
int_shifter.sv
mul_step_counter.sv
mul_sequencer.sv
mul_datapath.sv
int_alu.sv
int_exec_unit.sv
tb_int_exec.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_int_exec -f tb.f -o sim_int_exec
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_int_exec 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
